// File: build.f
verilog/uart_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_rx.sv
verilog/rx_fifo.sv
verilog/uart_rx_top.sv
verification/uart_rx_asserts.sv
verification/tb_uart_rx.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module tb_uart_rx; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_uart_rx)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -Fxq "Simulation completed successfully"; then
	exit 0
fi
exit 1

// File: verification/tb_uart_rx.sv
`default_nettype none

module tb_uart_rx import uart_pkg::*; ();

	localparam int TOTAL_FRAMES   = 20 + 12 + 2 + 5 + FIFO_DEPTH + 1;
	localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * 12 * 160 + 20000;  // worst bit is 160 clocks

	logic        clk;
	logic        rst;
	logic        en;
	uart_cfg_t   cfg;
	logic        rx;
	logic        rd;
	rx_entry_t   entry;
	logic        empty;
	logic        full;
	logic        overrun;
	logic        busy;
	rx_entry_t   exp_q[$];  // reference model of the fifo contents
	logic        exp_overrun = 1'b0;
	int          error_count = 0;
	int          check_count = 0;
	int          cycle_count = 0;
	int unsigned lcg_state = 44;

	uart_rx_top dut (
		.clk     (clk),
		.rst     (rst),
		.en      (en),
		.cfg     (cfg),
		.rx      (rx),
		.rd      (rd),
		.entry   (entry),
		.empty   (empty),
		.full    (full),
		.overrun (overrun),
		.busy    (busy)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles waiting for a received frame", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 8;  // low bits of an LCG repeat quickly
	endfunction

	task automatic check_value(input string what, input int got, input int expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("[ERROR] %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, expected);
		end
	endtask

	task automatic hold_line(input logic level, input int clocks);
		rx <= level;
		repeat (clocks) @(posedge clk);
	endtask

	task automatic set_format(input logic [7:0] bdiv, input logic [1:0] dtype,
			input logic [1:0] stype, input logic chk_en, input logic [1:0] chk_type);
		cfg <= '{baud_div: bdiv, data_type: dtype, stop_type: stype,
			check_en: chk_en, check_type: chk_type};
		@(posedge clk);
	endtask

	// start bit, data LSB first, parity, stop bits, then one idle bit
	task automatic send_frame(input logic [7:0] data, input logic bad_parity,
			input logic bad_stop);
		int         bit_clocks;
		int         width;
		int         stop_clocks;
		logic [7:0] masked;
		logic [7:0] shifter;
		logic       parity;
		rx_entry_t  expected;
		bit_clocks = 80 * (int'(cfg.baud_div) + 1);
		width = 8 - int'(cfg.data_type);
		masked = data & 8'((1 << width) - 1);
		case (cfg.check_type)
			2'b00:   parity = ~(^masked);  // odd
			2'b01:   parity = ^masked;  // even
			2'b10:   parity = 1'b1;
			default: parity = 1'b0;
		endcase
		if (cfg.stop_type == 2'b00) begin
			stop_clocks = bit_clocks;
		end else if (cfg.stop_type == 2'b01) begin
			stop_clocks = bit_clocks * 3 / 2;
		end else begin
			stop_clocks = 2 * bit_clocks;
		end
		hold_line(1'b0, bit_clocks);
		check_value("busy during frame", int'(busy), 1);
		shifter = masked;
		for (int i = 0; i < width; i++) begin
			hold_line(shifter[0], bit_clocks);
			shifter = shifter >> 1;
		end
		if (cfg.check_en) begin
			hold_line(parity ^ bad_parity, bit_clocks);
		end
		if (bad_stop) begin
			hold_line(1'b0, bit_clocks);  // first stop bit pulled low
			stop_clocks -= bit_clocks;
		end
		if (stop_clocks > 0) begin
			hold_line(1'b1, stop_clocks);
		end
		hold_line(1'b1, bit_clocks);
		expected.data = masked;
		expected.err  = bad_parity | bad_stop;
		if (exp_q.size() < FIFO_DEPTH) begin
			exp_q.push_back(expected);
		end else begin
			exp_overrun = 1'b1;  // entry lost in the full fifo
		end
	endtask

	task automatic read_entry(input string what);
		rx_entry_t expected;
		while (empty) begin
			@(posedge clk);
		end
		expected = exp_q.pop_front();
		check_value({what, " data"}, int'(entry.data), int'(expected.data));
		check_value({what, " err"}, int'(entry.err), int'(expected.err));
		rd <= 1'b1;
		@(posedge clk);
		rd <= 1'b0;
		@(posedge clk);  // let empty settle before the next pop
	endtask

	task automatic drain_entries(input string what);
		while (exp_q.size() > 0) begin
			read_entry(what);
		end
	endtask

	initial begin
		int errors_before;
		rst <= 1'b1;
		en  <= 1'b0;
		rx  <= 1'b1;
		rd  <= 1'b0;
		cfg <= '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		en  <= 1'b1;
		repeat (4) @(posedge clk);

		errors_before = error_count;
		check_value("empty after reset", int'(empty), 1);
		check_value("full after reset", int'(full), 0);
		check_value("overrun after reset", int'(overrun), 0);
		check_value("busy after reset", int'(busy), 0);
		set_format(8'd0, 2'b00, 2'b00, 1'b0, 2'b00);
		for (int i = 0; i < 20; i++) begin
			send_frame(8'(next_random()), 1'b0, 1'b0);
			drain_entries("8N1 frame");
		end
		$display("test 1 8N1 frames: %0d mismatches", error_count - errors_before);

		errors_before = error_count;
		for (int i = 0; i < 12; i++) begin
			set_format(8'd0, 2'(next_random() % 3 + 1), 2'b01, 1'b1, 2'(next_random() % 2));
			send_frame(8'(next_random()), 1'b0, 1'b0);
			drain_entries("short word");
		end
		$display("test 2 short words with parity: %0d mismatches", error_count - errors_before);

		errors_before = error_count;
		set_format(8'd0, 2'b00, 2'b00, 1'b1, 2'b01);
		send_frame(8'(next_random()), 1'b1, 1'b0);  // parity bit inverted
		drain_entries("parity error frame");
		send_frame(8'(next_random()), 1'b0, 1'b0);
		drain_entries("frame after parity error");
		$display("test 3 parity error: %0d mismatches", error_count - errors_before);

		errors_before = error_count;
		set_format(8'd0, 2'b00, 2'b10, 1'b0, 2'b00);
		send_frame(8'(next_random()), 1'b0, 1'b1);
		drain_entries("framing error frame");
		for (int i = 0; i < 4; i++) begin
			set_format(8'd1, 2'(next_random() % 2), 2'b10, 1'b1, (i < 2) ? 2'b10 : 2'b11);
			send_frame(8'(next_random()), 1'b0, 1'b0);
			drain_entries("mark or space frame");
		end
		$display("test 4 framing error: %0d mismatches", error_count - errors_before);

		errors_before = error_count;
		set_format(8'd0, 2'b00, 2'b00, 1'b0, 2'b00);
		for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
			send_frame(8'(next_random()), 1'b0, 1'b0);  // no reads in between
		end
		check_value("full after overflow", int'(full), 1);
		check_value("overrun after overflow", int'(overrun), int'(exp_overrun));
		drain_entries("buffered frame");
		check_value("empty after drain", int'(empty), 1);
		$display("test 5 overflow: %0d mismatches", error_count - errors_before);

		$display("tests done: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/uart_rx_asserts.sv
`default_nettype none

// protocol checks bound into the receive subsystem
module uart_rx_asserts (
	input logic clk,
	input logic rst,
	input logic push,  // receiver push, taken from inside the top level
	input logic busy,
	input logic empty,
	input logic full,
	input logic overrun
);

	reset_flags: assert property (@(posedge clk) rst |=> (!push && !overrun && !busy))
		else $error("push, overrun or busy still high after reset");

	fifo_levels: assert property (@(posedge clk) !(empty && full))
		else $error("fifo shows empty and full together");

	// overrun is sticky, only reset may clear it
	overrun_held: assert property (@(posedge clk) $fell(overrun) |-> $past(rst))
		else $error("overrun dropped without reset");

endmodule

bind uart_rx_top uart_rx_asserts u_asserts (
	.clk     (clk),
	.rst     (rst),
	.push    (u_rx.push),
	.busy    (busy),
	.empty   (empty),
	.full    (full),
	.overrun (overrun)
);

`default_nettype wire

// File: verilog/rx_fifo.sv
`default_nettype none

// Circular buffer for received frames.
// Pointers carry one extra bit so that full and empty differ only in
// the wrap bit. The head entry is shown without a read latency.
module rx_fifo import uart_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      push,  // from the receiver, cannot be stalled
	input  rx_entry_t wr_entry,
	input  logic      rd,  // host pops the head entry
	output rx_entry_t rd_entry,
	output logic      empty,
	output logic      full,
	output logic      overrun  // sticky until reset
);

	rx_entry_t          mem [FIFO_DEPTH];
	logic [FIFO_AW:0]   wr_ptr;
	logic [FIFO_AW:0]   rd_ptr;
	logic               do_write;
	logic               do_read;

	assign empty = wr_ptr == rd_ptr;
	assign full  = (wr_ptr[FIFO_AW] != rd_ptr[FIFO_AW]) &&
		(wr_ptr[FIFO_AW-1:0] == rd_ptr[FIFO_AW-1:0]);

	assign do_write = push && !full;  // entry lost when full
	assign do_read  = rd && !empty;

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr[FIFO_AW-1:0]] <= wr_entry;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (do_write) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_ptr <= '0;
		end else if (do_read) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			overrun <= 1'b0;
		end else if (push && full) begin
			overrun <= 1'b1;
		end
	end

	assign rd_entry = mem[rd_ptr[FIFO_AW-1:0]];  // valid while not empty

endmodule

`default_nettype wire

// File: verilog/uart_baud_gen.sv
`default_nettype none

// Two-stage divider that paces the receiver's oversampling.
// The prescaler brings the system clock down to the 10 MHz base, and the
// second stage divides that by baud_div+1. Both stages sit at zero while
// restart is high, so the first tick lands a fixed time after restart falls.
module uart_baud_gen import uart_pkg::*; (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      restart,  // level, held by the receiver while idle
	input  logic [BAUD_DIV_WIDTH-1:0] baud_div,
	output logic                      tick  // one clock wide
);

	logic [$clog2(CLK_DIV)-1:0] clk_count;  // prescaler stage
	logic [BAUD_DIV_WIDTH-1:0]  div_count;  // baud divider stage
	logic                       pre_wrap;
	logic                       div_wrap;

	assign pre_wrap = clk_count == $bits(clk_count)'(CLK_DIV - 1);
	assign div_wrap = div_count == baud_div;

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			clk_count <= '0;
		end else if (pre_wrap) begin
			clk_count <= '0;
		end else begin
			clk_count <= clk_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			div_count <= '0;
		end else if (pre_wrap) begin
			if (div_wrap) begin
				div_count <= '0;
			end else begin
				div_count <= div_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			tick <= 1'b0;
		end else begin
			tick <= pre_wrap && div_wrap;  // one pulse per full divider wrap
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

	// clock and oversampling
	localparam int CLK_DIV        = 10;  // 100 MHz system clock down to a 10 MHz base
	localparam int BAUD_DIV_WIDTH = 8;
	localparam int SAMPLE_COUNT   = 8;   // ticks per serial bit
	localparam int SAMPLE_WIDTH   = 3;
	localparam int MAJORITY       = 4;   // agreeing samples for an early stop decision

	// receive buffer
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW    = 4;

	// line format, held stable by the host while a frame is on the wire
	typedef struct packed {
		logic [BAUD_DIV_WIDTH-1:0] baud_div;  // tick period is CLK_DIV*(baud_div+1) clocks
		logic [1:0]                data_type;  // 00 eight bits, 01 seven, 10 six, 11 five
		logic [1:0]                stop_type;  // 00 one, 01 one and a half, 10 two
		logic                      check_en;  // parity bit present
		logic [1:0]                check_type;  // 00 odd, 01 even, 10 mark, 11 space
	} uart_cfg_t;

	// one received frame as stored in the fifo
	typedef struct packed {
		logic [7:0] data;  // right aligned, unused upper bits zero
		logic       err;  // bad start, parity or stop bit
	} rx_entry_t;

endpackage

`default_nettype wire

// File: verilog/uart_rx.sv
`default_nettype none

// UART frame receiver.
// Each bit spans SAMPLE_COUNT ticks; the line is sampled on the first
// seven ticks and the bit is decided by majority on the eighth.
// A frame is start, 5 to 8 data bits LSB first, optional parity, and
// one, one and a half or two stop bits. Every frame ends in a push.
module uart_rx import uart_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      en,  // allows a new start edge to be taken
	input  uart_cfg_t cfg,
	input  logic      rx,  // serial line, idles high
	input  logic      tick,  // oversampling tick from the baud generator
	output logic      restart,  // clears the tick generator and the sample counters
	output logic      push,  // frame finished, entry valid
	output rx_entry_t entry,
	output logic      busy
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_CHECK,
		S_STOP0,
		S_STOP1,
		S_DONE,
		S_ERROR
	} state_t;

	state_t state;
	state_t next_state;

	logic [SAMPLE_WIDTH-1:0] sample_count;  // ticks seen in the current bit
	logic [SAMPLE_WIDTH-1:0] pos_count;  // high samples
	logic [SAMPLE_WIDTH-1:0] neg_count;  // low samples
	logic                    bit_ready;  // curr_bit valid for one cycle
	logic                    curr_bit;
	logic                    rx_prev;
	logic [2:0]              bit_cnt;  // index of the data bit being received
	logic                    last_bit;
	logic [7:0]              shift_data;
	logic                    check_bit;  // expected parity
	logic                    stop_high;
	logic                    stop_low;

	// sampling and majority vote
	always_ff @(posedge clk) begin
		bit_ready <= 1'b0;
		if (rst || restart) begin
			sample_count <= '0;
			pos_count    <= '0;
			neg_count    <= '0;
		end else if (tick) begin
			if (sample_count != SAMPLE_WIDTH'(SAMPLE_COUNT - 1)) begin
				sample_count <= sample_count + 1'b1;
				if (rx) begin
					pos_count <= pos_count + 1'b1;
				end else begin
					neg_count <= neg_count + 1'b1;
				end
			end else begin
				bit_ready    <= 1'b1;
				curr_bit     <= pos_count > neg_count;  // seven samples, never a tie
				sample_count <= '0;
				pos_count    <= '0;
				neg_count    <= '0;
			end
		end
	end

	// previous line level for start edge detection
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_prev <= 1'b0;
		end else begin
			rx_prev <= rx;
		end
	end

	// data_type counts the bits dropped from a full byte
	assign last_bit = bit_cnt == (3'd7 - {1'b0, cfg.data_type});

	// a stop bit that is not sampled to the end is decided on MAJORITY samples
	assign stop_high = pos_count == SAMPLE_WIDTH'(MAJORITY);
	assign stop_low  = neg_count == SAMPLE_WIDTH'(MAJORITY);

	// shift_data is already right aligned once parity is checked
	always_comb begin
		case (cfg.check_type)
			2'b00:   check_bit = ~(^shift_data);
			2'b01:   check_bit = ^shift_data;
			2'b10:   check_bit = 1'b1;
			default: check_bit = 1'b0;
		endcase
	end

	always_comb begin
		next_state = state;
		restart    = 1'b0;
		case (state)
			S_IDLE: begin
				restart = 1'b1;
				if (en && rx_prev && !rx) begin
					next_state = S_START;
				end
			end
			S_START: begin
				if (bit_ready) begin
					next_state = curr_bit ? S_ERROR : S_DATA;
				end
			end
			S_DATA: begin
				if (bit_ready && last_bit) begin
					next_state = cfg.check_en ? S_CHECK : S_STOP0;
				end
			end
			S_CHECK: begin
				if (bit_ready) begin
					next_state = (curr_bit != check_bit) ? S_ERROR : S_STOP0;
				end
			end
			S_STOP0: begin
				if (cfg.stop_type[1]) begin  // two stop bits, first one sampled in full
					if (bit_ready) begin
						next_state = curr_bit ? S_STOP1 : S_ERROR;
					end
				end else if (stop_high) begin
					restart    = 1'b1;
					next_state = S_DONE;
				end else if (stop_low) begin
					restart    = 1'b1;
					next_state = S_ERROR;
				end
			end
			S_STOP1: begin
				if (stop_high) begin
					restart    = 1'b1;
					next_state = S_DONE;
				end else if (stop_low) begin
					restart    = 1'b1;
					next_state = S_ERROR;
				end
			end
			S_DONE, S_ERROR: begin
				next_state = rx ? S_IDLE : S_START;  // line already low, next start bit
			end
			default: begin
				next_state = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bit_cnt <= '0;
		end else if (state == S_START) begin
			bit_cnt <= '0;
		end else if (state == S_DATA && bit_ready) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// LSB first, so each new bit enters at the top
	always_ff @(posedge clk) begin
		if (state == S_START) begin
			shift_data <= '0;
		end else if (state == S_DATA && bit_ready) begin
			if (last_bit) begin
				shift_data <= {curr_bit, shift_data[7:1]} >> cfg.data_type;
			end else begin
				shift_data <= {curr_bit, shift_data[7:1]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			push <= 1'b0;
		end else begin
			push <= (state == S_DONE) || (state == S_ERROR);
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_DONE || state == S_ERROR) begin
			entry.data <= shift_data;
			entry.err  <= state == S_ERROR;
		end
	end

	assign busy = state != S_IDLE;

endmodule

`default_nettype wire

// File: verilog/uart_rx_top.sv
`default_nettype none

// UART receive subsystem.
// The receiver and its tick generator produce frames; the FIFO holds them
// until the host reads them through the strobe interface.
module uart_rx_top import uart_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      en,  // start detection enable
	input  uart_cfg_t cfg,  // line format and baud divider
	input  logic      rx,  // serial input
	input  logic      rd,  // pop strobe
	output rx_entry_t entry,  // fifo head, valid while empty is low
	output logic      empty,
	output logic      full,
	output logic      overrun,
	output logic      busy  // frame in progress
);

	logic      restart;
	logic      tick;
	logic      push;
	rx_entry_t rx_entry;

	uart_baud_gen u_baud_gen (
		.clk      (clk),
		.rst      (rst),
		.restart  (restart),
		.baud_div (cfg.baud_div),
		.tick     (tick)
	);

	uart_rx u_rx (
		.clk     (clk),
		.rst     (rst),
		.en      (en),
		.cfg     (cfg),
		.rx      (rx),
		.tick    (tick),
		.restart (restart),
		.push    (push),
		.entry   (rx_entry),
		.busy    (busy)
	);

	rx_fifo u_fifo (
		.clk      (clk),
		.rst      (rst),
		.push     (push),
		.wr_entry (rx_entry),
		.rd       (rd),
		.rd_entry (entry),
		.empty    (empty),
		.full     (full),
		.overrun  (overrun)
	);

endmodule

`default_nettype wire
